// File: include/bp_defs.svh
`ifndef BP_DEFS_SVH
`define BP_DEFS_SVH

// Local history table
`define BP_BHT_ENTRIES      256
`define BP_BHT_IDX_BITS     8
`define BP_LHR_LEN          10

// Local pattern table, indexed by history XOR PC
`define BP_LPHT_ENTRIES     1024
`define BP_LPHT_IDX_BITS    10

// Global history and gshare pattern table
`define BP_GHR_LEN          12
`define BP_GPHT_ENTRIES     4096
`define BP_GPHT_IDX_BITS    12

// Chooser table
`define BP_CHOICE_ENTRIES   1024
`define BP_CHOICE_IDX_BITS  10

// 2-bit saturating counters
`define BP_CTR_BITS         2

// PC index fields, word aligned
`define BP_PC_LO            2
`define BP_BHT_PC_HI        9
`define BP_LPHT_PC_HI       11
`define BP_CHOICE_PC_HI     11
`define BP_GPHT_PC_HI       13

`endif

// File: hdl/bp_pkg.sv
`include "bp_defs.svh"

package bp_pkg;

    typedef logic [`BP_BHT_IDX_BITS-1:0]    bht_index_t;
    typedef logic [`BP_LPHT_IDX_BITS-1:0]   lpht_index_t;
    typedef logic [`BP_GPHT_IDX_BITS-1:0]   gpht_index_t;
    typedef logic [`BP_CHOICE_IDX_BITS-1:0] choice_index_t;

    // History words, newest outcome in bit 0
    typedef logic [`BP_LHR_LEN-1:0] lhr_t;
    typedef logic [`BP_GHR_LEN-1:0] ghr_t;

    // Upper bit set means taken (or use global, in the chooser)
    typedef logic [`BP_CTR_BITS-1:0] counter_t;

    // Travels with a prediction and comes back at commit
    typedef struct packed {
        bht_index_t    bht_index;
        lpht_index_t   lpht_index;
        gpht_index_t   gpht_index;
        choice_index_t choice_index;
        logic          local_taken;
        logic          global_taken;
    } bp_meta_t;

    // Saturating step toward up or down
    function automatic counter_t ctr_next(counter_t ctr, logic up);
        counter_t result;
        result = ctr;
        if (up && ctr != '1) begin
            result = ctr + 1'b1;
        end else if (!up && ctr != '0) begin
            result = ctr - 1'b1;
        end
        return result;
    endfunction

endpackage

// File: hdl/bp_update_if.sv
`include "bp_defs.svh"

// One resolved branch, returned by the pipeline at commit
interface bp_update_if;

    logic                            valid;
    logic                            taken;
    logic [`BP_BHT_IDX_BITS-1:0]     bht_index;
    logic [`BP_LPHT_IDX_BITS-1:0]    lpht_index;
    logic [`BP_GPHT_IDX_BITS-1:0]    gpht_index;
    logic [`BP_CHOICE_IDX_BITS-1:0]  choice_index;
    logic                            local_taken;
    logic                            global_taken;

    modport source (
        output valid, taken, bht_index, lpht_index, gpht_index,
        output choice_index, local_taken, global_taken
    );

    modport predictor (
        input valid, taken, bht_index, lpht_index, gpht_index,
        input choice_index, local_taken, global_taken
    );

endinterface

// File: hdl/local_hist_predictor.sv
`include "bp_defs.svh"

module local_hist_predictor
    import bp_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 advance,
    input  logic [31:0]          lookup_pc,
    bp_update_if.predictor       upd,
    output logic                 taken,
    output bht_index_t           bht_index,
    output lpht_index_t          lpht_index
);

    // Per-branch histories and the shared pattern table
    lhr_t     bht [`BP_BHT_ENTRIES];
    counter_t pht [`BP_LPHT_ENTRIES];

    bht_index_t  bht_index_s1;
    lpht_index_t lpht_index_s1;
    lhr_t        hist_s1;
    lhr_t        hist_upd;
    counter_t    ctr_upd;

    // Stage 1
    assign bht_index_s1 = lookup_pc[`BP_BHT_PC_HI:`BP_PC_LO];

    // Committed history with the resolved outcome shifted in
    assign hist_upd = {bht[upd.bht_index][`BP_LHR_LEN-2:0], upd.taken};

    // A commit to the same entry at this edge must be seen by this lookup
    always_comb begin
        if (upd.valid && upd.bht_index == bht_index_s1) begin
            hist_s1 = hist_upd;
        end else begin
            hist_s1 = bht[bht_index_s1];
        end
    end

    assign lpht_index_s1 = lookup_pc[`BP_LPHT_PC_HI:`BP_PC_LO] ^ hist_s1;

    always_ff @(posedge clk) begin
        if (advance) begin
            bht_index  <= bht_index_s1;
            lpht_index <= lpht_index_s1;
        end
    end

    // Stage 2 reads straight from the registered index
    assign taken = pht[lpht_index][`BP_CTR_BITS-1];

    // Training
    assign ctr_upd = ctr_next(pht[upd.lpht_index], upd.taken);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `BP_BHT_ENTRIES; i++) begin
                bht[i] <= '0;
            end
            for (int i = 0; i < `BP_LPHT_ENTRIES; i++) begin
                pht[i] <= '0;
            end
        end else if (upd.valid) begin
            bht[upd.bht_index]  <= hist_upd;
            pht[upd.lpht_index] <= ctr_upd;
        end
    end

endmodule

// File: hdl/gshare_predictor.sv
`include "bp_defs.svh"

module gshare_predictor
    import bp_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 advance,
    input  logic [31:0]          lookup_pc,
    bp_update_if.predictor       upd,
    output logic                 taken,
    output gpht_index_t          gpht_index
);

    counter_t pht [`BP_GPHT_ENTRIES];

    // Committed global history, no speculative copy
    ghr_t ghr;
    ghr_t ghr_upd;
    ghr_t ghr_s1;

    gpht_index_t gpht_index_s1;
    counter_t    ctr_upd;

    assign ghr_upd = {ghr[`BP_GHR_LEN-2:0], upd.taken};

    // Forward a commit landing at the same edge
    assign ghr_s1 = upd.valid ? ghr_upd : ghr;

    always_ff @(posedge clk) begin
        if (rst) begin
            ghr <= '0;
        end else if (upd.valid) begin
            ghr <= ghr_upd;
        end
    end

    // Stage 1
    assign gpht_index_s1 = lookup_pc[`BP_GPHT_PC_HI:`BP_PC_LO] ^ ghr_s1;

    always_ff @(posedge clk) begin
        if (advance) begin
            gpht_index <= gpht_index_s1;
        end
    end

    // Stage 2
    assign taken = pht[gpht_index][`BP_CTR_BITS-1];

    // Train at the index this branch was predicted with
    assign ctr_upd = ctr_next(pht[upd.gpht_index], upd.taken);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `BP_GPHT_ENTRIES; i++) begin
                pht[i] <= '0;
            end
        end else if (upd.valid) begin
            pht[upd.gpht_index] <= ctr_upd;
        end
    end

endmodule

// File: hdl/tournament_chooser.sv
`include "bp_defs.svh"

module tournament_chooser
    import bp_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 advance,
    input  logic [31:0]          lookup_pc,
    bp_update_if.predictor       upd,
    output logic                 use_global,
    output choice_index_t        choice_index
);

    // Upper bit set selects gshare
    counter_t choice [`BP_CHOICE_ENTRIES];

    choice_index_t choice_index_s1;
    logic          disagree;
    logic          global_right;
    counter_t      ctr_upd;

    // Stage 1
    assign choice_index_s1 = lookup_pc[`BP_CHOICE_PC_HI:`BP_PC_LO];

    always_ff @(posedge clk) begin
        if (advance) begin
            choice_index <= choice_index_s1;
        end
    end

    // Stage 2
    assign use_global = choice[choice_index][`BP_CTR_BITS-1];

    // Only train when the two components disagreed
    assign disagree     = upd.local_taken != upd.global_taken;
    assign global_right = upd.global_taken == upd.taken;
    assign ctr_upd      = ctr_next(choice[upd.choice_index], global_right);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `BP_CHOICE_ENTRIES; i++) begin
                choice[i] <= '0;
            end
        end else if (upd.valid && disagree) begin
            choice[upd.choice_index] <= ctr_upd;
        end
    end

endmodule

// File: hdl/branch_predictor.sv
module branch_predictor
    import bp_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        pause,

    // Lookup
    input  logic        lookup_valid,
    input  logic [31:0] lookup_pc,
    output logic        pred_valid,
    output logic        pred_taken,
    output logic [31:0] pred_pc,
    output bp_meta_t    pred_meta,

    // Commit
    input  logic        commit_valid,
    input  logic        commit_taken,
    input  bp_meta_t    commit_meta
);

    bp_update_if upd_bus ();

    logic          advance;
    logic          local_taken;
    logic          global_taken;
    logic          use_global;
    bht_index_t    bht_index;
    lpht_index_t   lpht_index;
    gpht_index_t   gpht_index;
    choice_index_t choice_index;

    // Commit bundle fans out to all three tables
    assign upd_bus.valid        = commit_valid;
    assign upd_bus.taken        = commit_taken;
    assign upd_bus.bht_index    = commit_meta.bht_index;
    assign upd_bus.lpht_index   = commit_meta.lpht_index;
    assign upd_bus.gpht_index   = commit_meta.gpht_index;
    assign upd_bus.choice_index = commit_meta.choice_index;
    assign upd_bus.local_taken  = commit_meta.local_taken;
    assign upd_bus.global_taken = commit_meta.global_taken;

    // Stage 1 captures a lookup unless the front end is stalled
    assign advance = lookup_valid && !pause;

    local_hist_predictor local_i (
        .clk        (clk),
        .rst        (rst),
        .advance    (advance),
        .lookup_pc  (lookup_pc),
        .upd        (upd_bus.predictor),
        .taken      (local_taken),
        .bht_index  (bht_index),
        .lpht_index (lpht_index)
    );

    gshare_predictor gshare_i (
        .clk        (clk),
        .rst        (rst),
        .advance    (advance),
        .lookup_pc  (lookup_pc),
        .upd        (upd_bus.predictor),
        .taken      (global_taken),
        .gpht_index (gpht_index)
    );

    tournament_chooser chooser_i (
        .clk          (clk),
        .rst          (rst),
        .advance      (advance),
        .lookup_pc    (lookup_pc),
        .upd          (upd_bus.predictor),
        .use_global   (use_global),
        .choice_index (choice_index)
    );

    // Valid bit holds while paused
    always_ff @(posedge clk) begin
        if (rst) begin
            pred_valid <= 1'b0;
        end else if (!pause) begin
            pred_valid <= lookup_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            pred_pc <= lookup_pc;
        end
    end

    assign pred_taken = use_global ? global_taken : local_taken;

    always_comb begin
        pred_meta.bht_index    = bht_index;
        pred_meta.lpht_index   = lpht_index;
        pred_meta.gpht_index   = gpht_index;
        pred_meta.choice_index = choice_index;
        pred_meta.local_taken  = local_taken;
        pred_meta.global_taken = global_taken;
    end

endmodule

// File: test/bp_clock_gen.sv
module bp_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // Reset held for the first four rising edges
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: test/bp_assertions.sv
module bp_assertions (
    input logic clk,
    input logic rst,
    input logic pause,
    input logic lookup_valid,
    input logic pred_valid,
    input logic pred_taken
);

    // Stage register clears under reset
    valid_low_in_reset: assert property (
        @(posedge clk) rst |=> !pred_valid
    ) else $error("pred_valid high while rst is asserted");

    // One cycle lookup latency
    lookup_gives_valid: assert property (
        @(posedge clk) disable iff (rst)
        (lookup_valid && !pause) |=> pred_valid
    ) else $error("pred_valid missing one cycle after an unpaused lookup");

    known_prediction: assert property (
        @(posedge clk) disable iff (rst)
        pred_valid |-> !$isunknown(pred_taken)
    ) else $error("pred_taken unknown while pred_valid is high");

endmodule

bind branch_predictor bp_assertions bp_assertions_i (
    .clk          (clk),
    .rst          (rst),
    .pause        (pause),
    .lookup_valid (lookup_valid),
    .pred_valid   (pred_valid),
    .pred_taken   (pred_taken)
);

// File: test/bp_tb.sv
`include "bp_defs.svh"

module bp_tb
    import bp_pkg::*;
();

    localparam int N_RESET = 16;
    localparam int N_SAT = 24;
    localparam int N_LOOP = 60;
    localparam int N_RAND = 200;
    localparam int N_PAUSE = 6;
    localparam int TOTAL_ITEMS = N_RESET + 2 * N_SAT + N_LOOP + N_RAND + 2;
    localparam int CYCLE_LIMIT = 20 * TOTAL_ITEMS;

    logic        clk;
    logic        rst;
    logic        pause;
    logic        lookup_valid;
    logic [31:0] lookup_pc;
    logic        pred_valid;
    logic        pred_taken;
    logic [31:0] pred_pc;
    bp_meta_t    pred_meta;
    logic        commit_valid;
    logic        commit_taken;
    bp_meta_t    commit_meta;

    // Reference copies of every table
    lhr_t     bht_m    [`BP_BHT_ENTRIES];
    counter_t lpht_m   [`BP_LPHT_ENTRIES];
    counter_t gpht_m   [`BP_GPHT_ENTRIES];
    counter_t choice_m [`BP_CHOICE_ENTRIES];
    ghr_t     ghr_m;

    logic [31:0] lfsr_state = 32'h225f342a;
    int          errors = 0;
    int          checks = 0;
    int          cycle_count = 0;
    logic        got_taken;
    logic [31:0] got_pc;
    bp_meta_t    got_meta;

    bp_clock_gen clock_gen_i (
        .clk (clk),
        .rst (rst)
    );

    branch_predictor branch_predictor_i (
        .clk          (clk),
        .rst          (rst),
        .pause        (pause),
        .lookup_valid (lookup_valid),
        .lookup_pc    (lookup_pc),
        .pred_valid   (pred_valid),
        .pred_taken   (pred_taken),
        .pred_pc      (pred_pc),
        .pred_meta    (pred_meta),
        .commit_valid (commit_valid),
        .commit_taken (commit_taken),
        .commit_meta  (commit_meta)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    function automatic counter_t sat_count(input counter_t c, input logic up);
        int v;
        v = int'(c) + (up ? 1 : -1);
        if (v < 0) begin
            v = 0;
        end
        if (v > 3) begin
            v = 3;
        end
        return counter_t'(v);
    endfunction

    task automatic model_reset();
        foreach (bht_m[i]) bht_m[i] = '0;
        foreach (lpht_m[i]) lpht_m[i] = '0;
        foreach (gpht_m[i]) gpht_m[i] = '0;
        foreach (choice_m[i]) choice_m[i] = '0;
        ghr_m = '0;
    endtask

    task automatic model_predict(input logic [31:0] pc, output bp_meta_t m, output logic t);
        logic use_glb;
        m.bht_index    = pc[`BP_BHT_PC_HI:`BP_PC_LO];
        m.lpht_index   = pc[`BP_LPHT_PC_HI:`BP_PC_LO] ^ bht_m[m.bht_index];
        m.gpht_index   = pc[`BP_GPHT_PC_HI:`BP_PC_LO] ^ ghr_m;
        m.choice_index = pc[`BP_CHOICE_PC_HI:`BP_PC_LO];
        m.local_taken  = lpht_m[m.lpht_index][1];
        m.global_taken = gpht_m[m.gpht_index][1];
        use_glb = choice_m[m.choice_index][1];
        t = use_glb ? m.global_taken : m.local_taken;
    endtask

    task automatic model_train(input bp_meta_t m, input logic t);
        lpht_m[m.lpht_index] = sat_count(lpht_m[m.lpht_index], t);
        bht_m[m.bht_index] = {bht_m[m.bht_index][`BP_LHR_LEN-2:0], t};
        gpht_m[m.gpht_index] = sat_count(gpht_m[m.gpht_index], t);
        ghr_m = {ghr_m[`BP_GHR_LEN-2:0], t};
        // Chooser moves only when the components disagreed
        if (m.local_taken != m.global_taken) begin
            choice_m[m.choice_index] = sat_count(choice_m[m.choice_index],
                                                 m.global_taken == t);
        end
    endtask

    task automatic check_field(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR t=%0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic do_lookup(input logic [31:0] pc);
        int waited;
        @(posedge clk);
        lookup_valid <= 1'b1;
        lookup_pc    <= pc;
        @(posedge clk);
        lookup_valid <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (!pred_valid && waited < 4) begin
            @(negedge clk);
            waited++;
        end
        if (!pred_valid) begin
            errors++;
            $display("pred_valid never rose after the lookup of pc %0h", pc);
        end
        got_taken = pred_taken;
        got_pc    = pred_pc;
        got_meta  = pred_meta;
    endtask

    task automatic check_prediction(input logic [31:0] pc, input bp_meta_t m,
                                    input logic t);
        check_field("pred_pc", got_pc, pc);
        check_field("pred_taken", got_taken, t);
        check_field("bht_index", got_meta.bht_index, m.bht_index);
        check_field("lpht_index", got_meta.lpht_index, m.lpht_index);
        check_field("gpht_index", got_meta.gpht_index, m.gpht_index);
        check_field("choice_index", got_meta.choice_index, m.choice_index);
        check_field("local_taken", got_meta.local_taken, m.local_taken);
        check_field("global_taken", got_meta.global_taken, m.global_taken);
    endtask

    // Returns the DUT's own meta, as the pipeline would
    task automatic do_commit(input logic outcome, input bp_meta_t model_meta);
        @(posedge clk);
        commit_valid <= 1'b1;
        commit_taken <= outcome;
        commit_meta  <= got_meta;
        @(posedge clk);
        commit_valid <= 1'b0;
        model_train(model_meta, outcome);
    endtask

    task automatic run_item(input logic [31:0] pc, input logic outcome);
        bp_meta_t exp_meta;
        logic     exp_taken;
        model_predict(pc, exp_meta, exp_taken);
        do_lookup(pc);
        check_prediction(pc, exp_meta, exp_taken);
        do_commit(outcome, exp_meta);
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        $display("test %0d %s finished with %0d errors", num, name, errors - errs_before);
    endtask

    initial begin
        int          errs_before;
        logic [31:0] r;
        logic [31:0] pc;
        logic [31:0] held_pc;
        bp_meta_t    held_meta;
        bp_meta_t    exp_meta;
        logic        exp_taken;

        pause        <= 1'b0;
        lookup_valid <= 1'b0;
        lookup_pc    <= '0;
        commit_valid <= 1'b0;
        commit_taken <= 1'b0;
        commit_meta  <= '0;
        model_reset();
        do @(negedge clk); while (rst);

        errs_before = errors;
        for (int i = 0; i < N_RESET; i++) begin
            take_bits(32, r);
            run_item({r[31:2], 2'b00}, 1'b0);
            check_field("reset pred_taken", got_taken, 1'b0);
            check_field("reset local_taken", got_meta.local_taken, 1'b0);
            check_field("reset global_taken", got_meta.global_taken, 1'b0);
        end
        report_test(1, "reset state", errs_before);

        errs_before = errors;
        take_bits(32, r);
        pc = {r[31:2], 2'b00};
        for (int i = 0; i < N_SAT; i++) begin
            run_item(pc, 1'b1);
        end
        check_field("trained taken", got_taken, 1'b1);
        for (int i = 0; i < N_SAT; i++) begin
            run_item(pc, 1'b0);
        end
        check_field("trained not taken", got_taken, 1'b0);
        report_test(2, "saturating training", errs_before);

        // Loop branch, taken twice then falls through
        errs_before = errors;
        take_bits(32, r);
        pc = {r[31:2], 2'b00};
        for (int i = 0; i < N_LOOP; i++) begin
            run_item(pc, (i % 3) != 2);
        end
        report_test(3, "local history", errs_before);

        // Few distinct branches so entries get retrained
        errs_before = errors;
        for (int i = 0; i < N_RAND; i++) begin
            take_bits(32, r);
            pc = r & 32'hffff_c03c;
            take_bits(2, r);
            run_item(pc, r[0] | r[1]);
        end
        report_test(4, "chooser", errs_before);

        errs_before = errors;
        take_bits(32, r);
        pc = {r[31:2], 2'b00};
        model_predict(pc, exp_meta, exp_taken);
        @(posedge clk);
        lookup_valid <= 1'b1;
        lookup_pc    <= pc;
        @(posedge clk);
        pause <= 1'b1;
        take_bits(32, r);
        lookup_pc <= {r[31:2], 2'b00};
        @(negedge clk);
        check_field("pred_valid before pause", pred_valid, 1'b1);
        got_taken = pred_taken;
        got_pc    = pred_pc;
        got_meta  = pred_meta;
        check_prediction(pc, exp_meta, exp_taken);
        held_pc   = pred_pc;
        held_meta = pred_meta;
        for (int i = 0; i < N_PAUSE; i++) begin
            @(posedge clk);
            take_bits(32, r);
            lookup_pc <= {r[31:2], 2'b00};
            @(negedge clk);
            check_field("paused pred_valid", pred_valid, 1'b1);
            check_field("paused pred_pc", pred_pc, held_pc);
            check_field("paused pred_meta", pred_meta, held_meta);
        end
        @(posedge clk);
        pause        <= 1'b0;
        lookup_valid <= 1'b0;
        @(negedge clk);
        check_field("last paused pred_pc", pred_pc, held_pc);
        @(posedge clk);
        @(negedge clk);
        check_field("pred_valid after pause", pred_valid, 1'b0);
        report_test(5, "pause", errs_before);

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: branch_predictor.f
+incdir+include
hdl/bp_pkg.sv
hdl/bp_update_if.sv
hdl/local_hist_predictor.sv
hdl/gshare_predictor.sv
hdl/tournament_chooser.sv
hdl/branch_predictor.sv
test/bp_clock_gen.sv
test/bp_assertions.sv
test/bp_tb.sv

// File: Bender.yml
package:
  name: branch_predictor

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/bp_pkg.sv
      - hdl/bp_update_if.sv
      - hdl/local_hist_predictor.sv
      - hdl/gshare_predictor.sv
      - hdl/tournament_chooser.sv
      - hdl/branch_predictor.sv

  - target: test
    include_dirs:
      - include
    files:
      - test/bp_clock_gen.sv
      - test/bp_assertions.sv
      - test/bp_tb.sv
